// ==== Bender.yml ====
package:
  name: back_end

sources:
  - verilog/backend_pkg.sv
  - verilog/backend_if.sv
  - verilog/phy_register.sv
  - verilog/dispatch.sv
  - verilog/alu_issue.sv
  - verilog/alu_execute.sv
  - verilog/commit.sv
  - verilog/back_end.sv
  - target: test
    files:
      - testbench/back_end_assert.sv
      - testbench/tb_back_end.sv

// ==== sim.f ====
verilog/backend_pkg.sv
verilog/backend_if.sv
verilog/phy_register.sv
verilog/dispatch.sv
verilog/alu_issue.sv
verilog/alu_execute.sv
verilog/commit.sv
verilog/back_end.sv
testbench/back_end_assert.sv
testbench/tb_back_end.sv

// ==== testbench/back_end_assert.sv ====
/* Concurrent assertions on the commit handshake, bound into back_end */
`timescale 1ns/100ps
`default_nettype none

module back_end_assert import backend_pkg::*; (
	input logic CLK,
	input logic i_rst,
	input logic i_commit_valid,
	input logic i_commit_ready,
	input areg_t i_commit_rd,
	input logic [XLEN-1:0] i_commit_data
);

	int fail_count = 0;

	// Empty reorder fifo right after reset
	assert property (@(posedge CLK) i_rst |=> !i_commit_valid)
		else begin
			$error("commit valid high after reset");
			fail_count++;
		end

	// Stalled output keeps valid and fields
	assert property (@(posedge CLK) disable iff (i_rst)
			i_commit_valid && !i_commit_ready |=>
			i_commit_valid && $stable(i_commit_rd) && $stable(i_commit_data))
		else begin
			$error("commit output changed while stalled");
			fail_count++;
		end

	assert property (@(posedge CLK) disable iff (i_rst)
			i_commit_valid |-> !$isunknown({i_commit_rd, i_commit_data}))
		else begin
			$error("unknown commit field while valid");
			fail_count++;
		end

endmodule

bind back_end back_end_assert u_back_end_assert (
	.CLK(CLK),
	.i_rst(i_rst),
	.i_commit_valid(o_commit_valid),
	.i_commit_ready(i_commit_ready),
	.i_commit_rd(o_commit_rd),
	.i_commit_data(o_commit_data)
);

`default_nettype wire

// ==== testbench/tb_back_end.sv ====
/* Back end testbench: clock, reset, LCG random stimulus, in-order
   reference model, commit checks and cycle limit */
`timescale 1ns/100ps
`default_nettype none

module tb_back_end import backend_pkg::*; ();

	localparam int NUM_INSTR = 32 + 400 + 12;
	localparam int CYCLE_LIMIT = 20 * NUM_INSTR + 100;

	logic CLK;
	logic i_rst;
	logic i_instr_valid;
	logic o_instr_ready;
	alu_op_e i_instr_op;
	areg_t i_instr_rd;
	areg_t i_instr_rs1;
	areg_t i_instr_rs2;
	logic [XLEN-1:0] i_instr_imm;
	logic o_commit_valid;
	logic i_commit_ready;
	areg_t o_commit_rd;
	logic [XLEN-1:0] o_commit_data;

	logic [31:0] rng;
	logic [31:0] ready_rng;
	// 0 always ready, 1 random, 2 held low
	int commit_mode;
	int cycle_count = 0;
	int accept_count = 0;
	int commit_count = 0;
	logic saw_drop;

	// In-order reference model and expected commit stream
	logic [XLEN-1:0] model_reg [AREG_NUM];
	logic [XLEN-1:0] model_res;
	areg_t exp_rd [$];
	logic [XLEN-1:0] exp_data [$];

	back_end dut (
		.CLK(CLK),
		.i_rst(i_rst),
		.i_instr_valid(i_instr_valid),
		.o_instr_ready(o_instr_ready),
		.i_instr_op(i_instr_op),
		.i_instr_rd(i_instr_rd),
		.i_instr_rs1(i_instr_rs1),
		.i_instr_rs2(i_instr_rs2),
		.i_instr_imm(i_instr_imm),
		.o_commit_valid(o_commit_valid),
		.i_commit_ready(i_commit_ready),
		.o_commit_rd(o_commit_rd),
		.o_commit_data(o_commit_data)
	);

	function automatic logic [31:0] lcg_step(input logic [31:0] s);
		return s * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic logic [31:0] draw();
		rng = lcg_step(rng);
		return rng;
	endfunction

	function automatic logic [XLEN-1:0] model_alu(input alu_op_e op, input logic [XLEN-1:0] a,
			input logic [XLEN-1:0] b, input logic [XLEN-1:0] imm);
		case (op)
			OP_LI:  return imm;
			OP_ADD: return a + b;
			OP_SUB: return a - b;
			OP_AND: return a & b;
			OP_OR:  return a | b;
			OP_XOR: return a ^ b;
			OP_SLL: return a << b[4:0];
			default: return 'x;
		endcase
	endfunction

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("Verification failed");
		$fatal(1);
	endtask

	task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
			input string what);
		if (actual !== expected) begin
			$display("FAILED at %0t ns: %s, got %0h, expected %0h", $time, what, actual,
				expected);
			$display("Verification failed");
			$fatal(1);
		end
	endtask

	// Raises valid and returns at the negedge before the accepting edge
	task automatic send_instr(input alu_op_e op, input areg_t rd, input areg_t rs1,
			input areg_t rs2, input logic [XLEN-1:0] imm);
		@(posedge CLK);
		#1;
		i_instr_valid = 1'b1;
		i_instr_op = op;
		i_instr_rd = rd;
		i_instr_rs1 = rs1;
		i_instr_rs2 = rs2;
		i_instr_imm = imm;
		@(negedge CLK);
		while (!o_instr_ready) @(negedge CLK);
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(posedge CLK);
			#1;
			i_instr_valid = 1'b0;
		end
	endtask

	task automatic drain();
		while (commit_count != accept_count) @(posedge CLK);
	endtask

	initial begin
		CLK = 1'b0;
		forever #2 CLK = ~CLK;
	end

	always @(posedge CLK) begin
		#1;
		case (commit_mode)
			0: i_commit_ready = 1'b1;
			1: begin
				ready_rng = lcg_step(ready_rng);
				// About 70 percent high
				i_commit_ready = (ready_rng[31:24] < 8'd179);
			end
			default: i_commit_ready = 1'b0;
		endcase
	end

	always @(posedge CLK) begin
		cycle_count++;
		if (cycle_count > CYCLE_LIMIT)
			abort_run("Timeout: the run exceeded its cycle limit");
	end

	// Transfers sampled mid-cycle and completed by the following edge
	always @(negedge CLK) begin
		if (!i_rst) begin
			if (o_commit_valid && i_commit_ready) begin
				if (exp_rd.size() == 0)
					abort_run("A commit appeared with no accepted instruction outstanding");
				check_value(o_commit_rd, exp_rd.pop_front(), "commit register");
				check_value(o_commit_data, exp_data.pop_front(), "commit data");
				commit_count++;
			end
			if (i_instr_valid && o_instr_ready) begin
				model_res = model_alu(i_instr_op, model_reg[i_instr_rs1],
					model_reg[i_instr_rs2], i_instr_imm);
				model_reg[i_instr_rd] = model_res;
				exp_rd.push_back(i_instr_rd);
				exp_data.push_back(model_res);
				accept_count++;
			end
		end
	end

	initial begin
		logic [31:0] r;
		logic [31:0] imm;
		alu_op_e op;
		int gap;

		i_rst = 1'b1;
		i_instr_valid = 1'b0;
		i_instr_op = OP_LI;
		i_instr_rd = '0;
		i_instr_rs1 = '0;
		i_instr_rs2 = '0;
		i_instr_imm = '0;
		i_commit_ready = 1'b1;
		commit_mode = 0;
		saw_drop = 1'b0;
		rng = 32'd25;
		ready_rng = draw();
		for (int i = 0; i < AREG_NUM; i++) model_reg[i] = '0;

		repeat (2) @(posedge CLK);
		#1;
		i_rst = 1'b0;
		@(negedge CLK);
		check_value(o_commit_valid, 1'b0, "commit valid after reset");
		check_value(o_instr_ready, 1'b1, "instruction ready after reset");

		// One LI per register
		for (int i = 0; i < AREG_NUM; i++) begin
			r = draw();
			send_instr(OP_LI, areg_t'(i), r[20:16], r[25:21], draw());
		end
		idle(1);
		drain();
		check_value(commit_count, 32, "commits after LI phase");

		// Random mix over eight registers with commit back-pressure
		commit_mode = 1;
		for (int i = 0; i < 400; i++) begin
			r = draw();
			imm = draw();
			op = (i < 7) ? alu_op_e'(i) : alu_op_e'(r[31:27] % 7);
			send_instr(op, r[20:18], r[23:21], r[26:24], imm);
			gap = (r[17:16] == 2'b00) ? int'(r[15:14]) + 1 : 0;
			idle(gap);
		end
		idle(1);
		drain();
		commit_mode = 0;
		check_value(commit_count, 32 + 400, "commits after random phase");

		// Burst to one register while commit is held off
		commit_mode = 2;
		fork
			begin
				for (int i = 0; i < 12; i++) begin
					r = draw();
					imm = draw();
					send_instr(alu_op_e'(r[31:27] % 7), 5'd9, r[20:16], r[25:21], imm);
				end
				idle(1);
			end
			begin
				// Long enough for the free copies of the target to run out
				repeat (24) begin
					@(negedge CLK);
					if (i_instr_valid && !o_instr_ready) saw_drop = 1'b1;
				end
				commit_mode = 0;
			end
		join
		drain();
		check_value(saw_drop, 1'b1, "instruction ready dropped under held commit");
		check_value(commit_count, NUM_INSTR, "total commits");
		check_value(dut.u_back_end_assert.fail_count, 0, "assertion failures");

		$display("Verification passed");
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog/alu_execute.sv ====
/* ALU: operand read from the selected copies, operation and
   registered writeback */
`timescale 1ns/100ps
`default_nettype none

module alu_execute import backend_pkg::*; #(
	parameter int RP = RP_DEFAULT,
	localparam int CW = copy_width(RP)
) (
	input logic CLK,
	input logic i_rst,
	input logic i_issue_valid,
	input alu_op_e i_issue_op,
	input logic [XLEN-1:0] i_issue_imm,
	input areg_t i_issue_rs1,
	input logic [CW-1:0] i_issue_rs1_copy,
	input areg_t i_issue_rs2,
	input logic [CW-1:0] i_issue_rs2_copy,
	input areg_t i_issue_rd,
	input logic [CW-1:0] i_issue_rd_copy,
	input logic [AREG_NUM-1:0][RP-1:0][XLEN-1:0] i_regfile,
	writeback_if.src wb
);

	logic [XLEN-1:0] op_a;
	logic [XLEN-1:0] op_b;
	logic [XLEN-1:0] res;

	assign op_a = i_regfile[i_issue_rs1][i_issue_rs1_copy];
	assign op_b = i_regfile[i_issue_rs2][i_issue_rs2_copy];

	always_comb begin
		case (i_issue_op)
			OP_LI:  res = i_issue_imm;
			OP_ADD: res = op_a + op_b;
			OP_SUB: res = op_a - op_b;
			OP_AND: res = op_a & op_b;
			OP_OR:  res = op_a | op_b;
			OP_XOR: res = op_a ^ op_b;
			// shift amount from the low 5 bits only
			OP_SLL: res = op_a << op_b[4:0];
			default: res = '0;
		endcase
	end

	always_ff @(posedge CLK) begin
		if (i_rst) wb.valid <= 1'b0;
		else wb.valid <= i_issue_valid;
	end

	always_ff @(posedge CLK) begin
		wb.rd <= i_issue_rd;
		wb.copy <= i_issue_rd_copy;
		wb.data <= res;
	end

endmodule

`default_nettype wire

// ==== verilog/alu_issue.sv ====
/* ALU issue buffer with source wakeup and oldest-ready selection */
`timescale 1ns/100ps
`default_nettype none

module alu_issue import backend_pkg::*; #(
	parameter int RP = RP_DEFAULT,
	parameter int IQ_DEPTH = IQ_DEPTH_DEFAULT,
	localparam int CW = copy_width(RP)
) (
	input logic CLK,
	input logic i_rst,
	dispatch_if.sink_iq dsp,
	writeback_if.wake wb,
	input logic [AREG_NUM-1:0][RP-1:0] i_wb_done,

	output logic o_issue_valid,
	output alu_op_e o_issue_op,
	output logic [XLEN-1:0] o_issue_imm,
	output areg_t o_issue_rs1,
	output logic [CW-1:0] o_issue_rs1_copy,
	output areg_t o_issue_rs2,
	output logic [CW-1:0] o_issue_rs2_copy,
	output areg_t o_issue_rd,
	output logic [CW-1:0] o_issue_rd_copy
);

	localparam int IW = $clog2(IQ_DEPTH);
	localparam int NW = $clog2(IQ_DEPTH + 1);
	typedef logic [CW-1:0] copy_t;

	typedef struct packed {
		alu_op_e op;
		logic [XLEN-1:0] imm;
		areg_t rd;
		copy_t rd_copy;
		areg_t rs1;
		copy_t rs1_copy;
		logic rs1_rdy;
		areg_t rs2;
		copy_t rs2_copy;
		logic rs2_rdy;
	} iq_entry_t;

	// Entries kept compacted, index 0 is the oldest
	iq_entry_t q [IQ_DEPTH];
	iq_entry_t q_nxt [IQ_DEPTH];
	iq_entry_t new_entry;
	logic [NW-1:0] cnt;
	logic [NW-1:0] cnt_nxt;
	logic sel_found;
	logic [IW-1:0] sel_idx;

	function automatic logic wake_hit(input areg_t r, input copy_t c);
		return wb.valid && (wb.rd == r) && (wb.copy == c);
	endfunction

	always_comb begin
		sel_found = 1'b0;
		sel_idx = '0;
		for (int i = IQ_DEPTH - 1; i >= 0; i--) begin
			if ((i < cnt) && q[i].rs1_rdy && q[i].rs2_rdy) begin
				sel_found = 1'b1;
				sel_idx = IW'(i);
			end
		end
	end

	// LI has no sources
	always_comb begin
		new_entry.op = dsp.op;
		new_entry.imm = dsp.imm;
		new_entry.rd = dsp.rd;
		new_entry.rd_copy = dsp.rd_copy;
		new_entry.rs1 = dsp.rs1;
		new_entry.rs1_copy = dsp.rs1_copy;
		new_entry.rs1_rdy = (dsp.op == OP_LI) || i_wb_done[dsp.rs1][dsp.rs1_copy] ||
			wake_hit(dsp.rs1, dsp.rs1_copy);
		new_entry.rs2 = dsp.rs2;
		new_entry.rs2_copy = dsp.rs2_copy;
		new_entry.rs2_rdy = (dsp.op == OP_LI) || i_wb_done[dsp.rs2][dsp.rs2_copy] ||
			wake_hit(dsp.rs2, dsp.rs2_copy);
	end

	always_comb begin
		q_nxt = q;
		for (int i = 0; i < IQ_DEPTH; i++) begin
			if (wake_hit(q[i].rs1, q[i].rs1_copy)) q_nxt[i].rs1_rdy = 1'b1;
			if (wake_hit(q[i].rs2, q[i].rs2_copy)) q_nxt[i].rs2_rdy = 1'b1;
		end
		// Close the gap left by the issued entry
		if (sel_found) begin
			for (int i = 0; i < IQ_DEPTH - 1; i++) begin
				if (i >= sel_idx) q_nxt[i] = q_nxt[i + 1];
			end
		end
		cnt_nxt = cnt - NW'(sel_found);
		if (dsp.push) begin
			q_nxt[cnt_nxt[IW-1:0]] = new_entry;
			cnt_nxt = cnt_nxt + 1'b1;
		end
	end

	assign dsp.iq_full = (cnt == NW'(IQ_DEPTH));

	always_ff @(posedge CLK) begin
		if (i_rst) begin
			cnt <= '0;
			o_issue_valid <= 1'b0;
		end else begin
			cnt <= cnt_nxt;
			o_issue_valid <= sel_found;
		end
	end

	always_ff @(posedge CLK) begin
		q <= q_nxt;
		o_issue_op <= q[sel_idx].op;
		o_issue_imm <= q[sel_idx].imm;
		o_issue_rs1 <= q[sel_idx].rs1;
		o_issue_rs1_copy <= q[sel_idx].rs1_copy;
		o_issue_rs2 <= q[sel_idx].rs2;
		o_issue_rs2_copy <= q[sel_idx].rs2_copy;
		o_issue_rd <= q[sel_idx].rd;
		o_issue_rd_copy <= q[sel_idx].rd_copy;
	end

endmodule

`default_nettype wire

// ==== verilog/back_end.sv ====
/* Back end top level: rename, ALU issue and execute, writeback and
   in-order commit */
`timescale 1ns/100ps
`default_nettype none

module back_end import backend_pkg::*; #(
	parameter int RP = RP_DEFAULT,
	parameter int IQ_DEPTH = IQ_DEPTH_DEFAULT,
	parameter int ROB_AW = ROB_AW_DEFAULT
) (
	input logic CLK,
	input logic i_rst,

	input logic i_instr_valid,
	output logic o_instr_ready,
	input alu_op_e i_instr_op,
	input areg_t i_instr_rd,
	input areg_t i_instr_rs1,
	input areg_t i_instr_rs2,
	input logic [XLEN-1:0] i_instr_imm,

	output logic o_commit_valid,
	input logic i_commit_ready,
	output areg_t o_commit_rd,
	output logic [XLEN-1:0] o_commit_data
);

	localparam int CW = copy_width(RP);

	logic [AREG_NUM-1:0][CW-1:0] rn_act;
	logic [AREG_NUM-1:0][RP-1:0] rn_busy;
	logic [AREG_NUM-1:0][RP-1:0] wb_done;
	logic [AREG_NUM-1:0][RP-1:0][XLEN-1:0] regfile;

	logic rename_set_valid;
	areg_t rename_set_reg;
	logic [CW-1:0] rename_set_copy;
	logic commit_set_valid;
	areg_t commit_set_reg;
	logic [CW-1:0] commit_set_copy;

	// Issue to execute
	logic issue_valid;
	alu_op_e issue_op;
	logic [XLEN-1:0] issue_imm;
	areg_t issue_rs1;
	logic [CW-1:0] issue_rs1_copy;
	areg_t issue_rs2;
	logic [CW-1:0] issue_rs2_copy;
	areg_t issue_rd;
	logic [CW-1:0] issue_rd_copy;

	dispatch_if #(.RP(RP)) dsp_if ();
	writeback_if #(.RP(RP)) wb_if ();

	phy_register #(.RP(RP)) u_phy_register (
		.CLK(CLK),
		.i_rst(i_rst),
		.wb(wb_if.sink),
		.i_rename_set_valid(rename_set_valid),
		.i_rename_set_reg(rename_set_reg),
		.i_rename_set_copy(rename_set_copy),
		.i_commit_set_valid(commit_set_valid),
		.i_commit_set_reg(commit_set_reg),
		.i_commit_set_copy(commit_set_copy),
		.o_rn_act(rn_act),
		.o_rn_busy(rn_busy),
		.o_wb_done(wb_done),
		.o_regfile(regfile)
	);

	dispatch #(.RP(RP)) u_dispatch (
		.i_instr_valid(i_instr_valid),
		.o_instr_ready(o_instr_ready),
		.i_instr_op(i_instr_op),
		.i_instr_rd(i_instr_rd),
		.i_instr_rs1(i_instr_rs1),
		.i_instr_rs2(i_instr_rs2),
		.i_instr_imm(i_instr_imm),
		.i_rn_act(rn_act),
		.i_rn_busy(rn_busy),
		.o_rename_set_valid(rename_set_valid),
		.o_rename_set_reg(rename_set_reg),
		.o_rename_set_copy(rename_set_copy),
		.dsp(dsp_if.src)
	);

	alu_issue #(.RP(RP), .IQ_DEPTH(IQ_DEPTH)) u_alu_issue (
		.CLK(CLK),
		.i_rst(i_rst),
		.dsp(dsp_if.sink_iq),
		.wb(wb_if.wake),
		.i_wb_done(wb_done),
		.o_issue_valid(issue_valid),
		.o_issue_op(issue_op),
		.o_issue_imm(issue_imm),
		.o_issue_rs1(issue_rs1),
		.o_issue_rs1_copy(issue_rs1_copy),
		.o_issue_rs2(issue_rs2),
		.o_issue_rs2_copy(issue_rs2_copy),
		.o_issue_rd(issue_rd),
		.o_issue_rd_copy(issue_rd_copy)
	);

	alu_execute #(.RP(RP)) u_alu_execute (
		.CLK(CLK),
		.i_rst(i_rst),
		.i_issue_valid(issue_valid),
		.i_issue_op(issue_op),
		.i_issue_imm(issue_imm),
		.i_issue_rs1(issue_rs1),
		.i_issue_rs1_copy(issue_rs1_copy),
		.i_issue_rs2(issue_rs2),
		.i_issue_rs2_copy(issue_rs2_copy),
		.i_issue_rd(issue_rd),
		.i_issue_rd_copy(issue_rd_copy),
		.i_regfile(regfile),
		.wb(wb_if.src)
	);

	commit #(.RP(RP), .ROB_AW(ROB_AW)) u_commit (
		.CLK(CLK),
		.i_rst(i_rst),
		.dsp(dsp_if.sink_rob),
		.i_wb_done(wb_done),
		.i_regfile(regfile),
		.o_commit_set_valid(commit_set_valid),
		.o_commit_set_reg(commit_set_reg),
		.o_commit_set_copy(commit_set_copy),
		.o_commit_valid(o_commit_valid),
		.i_commit_ready(i_commit_ready),
		.o_commit_rd(o_commit_rd),
		.o_commit_data(o_commit_data)
	);

endmodule

`default_nettype wire

// ==== verilog/backend_if.sv ====
/* Dispatch interface towards issue buffer and reorder fifo,
   writeback interface from the ALU */
`timescale 1ns/100ps
`default_nettype none

interface dispatch_if import backend_pkg::*; #(parameter int RP = RP_DEFAULT);
	localparam int CW = copy_width(RP);
	typedef logic [CW-1:0] copy_t;

	logic push;
	alu_op_e op;
	logic [XLEN-1:0] imm;
	areg_t rd;
	copy_t rd_copy;
	areg_t rs1;
	copy_t rs1_copy;
	areg_t rs2;
	copy_t rs2_copy;
	logic iq_full;
	logic rob_full;

	modport src (
		output push, op, imm, rd, rd_copy, rs1, rs1_copy, rs2, rs2_copy,
		input iq_full, rob_full
	);
	modport sink_iq (
		input push, op, imm, rd, rd_copy, rs1, rs1_copy, rs2, rs2_copy,
		output iq_full
	);
	// Reorder fifo only keeps the destination
	modport sink_rob (input push, rd, rd_copy, output rob_full);
endinterface

interface writeback_if import backend_pkg::*; #(parameter int RP = RP_DEFAULT);
	localparam int CW = copy_width(RP);

	logic valid;
	areg_t rd;
	logic [CW-1:0] copy;
	logic [XLEN-1:0] data;

	modport src (output valid, rd, copy, data);
	modport sink (input valid, rd, copy, data);
	modport wake (input valid, rd, copy);
endinterface

`default_nettype wire

// ==== verilog/backend_pkg.sv ====
/* Shared widths, parameter defaults, the ALU opcode enum and the
   copy index width helper for the back end */
`default_nettype none

package backend_pkg;

	// Data path and architectural register set
	localparam int XLEN     = 32;
	localparam int AREG_NUM = 32;

	typedef logic [4:0] areg_t;

	// Defaults for the top-level parameters
	localparam int RP_DEFAULT       = 4;
	localparam int IQ_DEPTH_DEFAULT = 4;
	localparam int ROB_AW_DEFAULT   = 3;

	typedef enum logic [2:0] {
		OP_LI,
		OP_ADD,
		OP_SUB,
		OP_AND,
		OP_OR,
		OP_XOR,
		OP_SLL
	} alu_op_e;

	// Bits needed to index one of rp copies
	function automatic int copy_width(input int rp);
		int w;
		w = (rp > 1) ? $clog2(rp) : 1;
		return w;
	endfunction

endpackage

`default_nettype wire

// ==== verilog/commit.sv ====
/* Reorder fifo and in-order retirement onto the commit handshake */
`timescale 1ns/100ps
`default_nettype none

module commit import backend_pkg::*; #(
	parameter int RP = RP_DEFAULT,
	parameter int ROB_AW = ROB_AW_DEFAULT,
	localparam int CW = copy_width(RP)
) (
	input logic CLK,
	input logic i_rst,
	dispatch_if.sink_rob dsp,
	input logic [AREG_NUM-1:0][RP-1:0] i_wb_done,
	input logic [AREG_NUM-1:0][RP-1:0][XLEN-1:0] i_regfile,

	output logic o_commit_set_valid,
	output areg_t o_commit_set_reg,
	output logic [CW-1:0] o_commit_set_copy,

	output logic o_commit_valid,
	input logic i_commit_ready,
	output areg_t o_commit_rd,
	output logic [XLEN-1:0] o_commit_data
);

	localparam int DEPTH = 1 << ROB_AW;
	typedef logic [CW-1:0] copy_t;

	typedef struct packed {
		areg_t rd;
		copy_t copy;
	} rob_entry_t;

	rob_entry_t rob [DEPTH];
	rob_entry_t head;
	logic [ROB_AW:0] wr_ptr;
	logic [ROB_AW:0] rd_ptr;
	logic empty;
	logic pop;

	assign empty = (wr_ptr == rd_ptr);
	assign dsp.rob_full = (wr_ptr[ROB_AW] != rd_ptr[ROB_AW]) &&
		(wr_ptr[ROB_AW-1:0] == rd_ptr[ROB_AW-1:0]);
	assign head = rob[rd_ptr[ROB_AW-1:0]];

	// Head retires once its result is written back
	assign o_commit_valid = ~empty & i_wb_done[head.rd][head.copy];
	assign o_commit_rd = head.rd;
	assign o_commit_data = i_regfile[head.rd][head.copy];
	assign pop = o_commit_valid & i_commit_ready;

	assign o_commit_set_valid = pop;
	assign o_commit_set_reg = head.rd;
	assign o_commit_set_copy = head.copy;

	always_ff @(posedge CLK) begin
		if (i_rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (dsp.push) wr_ptr <= wr_ptr + 1'b1;
			if (pop) rd_ptr <= rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge CLK) begin
		if (dsp.push) begin
			rob[wr_ptr[ROB_AW-1:0]] <= '{rd: dsp.rd, copy: dsp.rd_copy};
		end
	end

endmodule

`default_nettype wire

// ==== verilog/dispatch.sv ====
/* Input side: renames the destination onto a free copy and pushes
   the instruction to the issue buffer and the reorder fifo */
`timescale 1ns/100ps
`default_nettype none

module dispatch import backend_pkg::*; #(
	parameter int RP = RP_DEFAULT,
	localparam int CW = copy_width(RP)
) (
	input logic i_instr_valid,
	output logic o_instr_ready,
	input alu_op_e i_instr_op,
	input areg_t i_instr_rd,
	input areg_t i_instr_rs1,
	input areg_t i_instr_rs2,
	input logic [XLEN-1:0] i_instr_imm,

	input logic [AREG_NUM-1:0][CW-1:0] i_rn_act,
	input logic [AREG_NUM-1:0][RP-1:0] i_rn_busy,

	output logic o_rename_set_valid,
	output areg_t o_rename_set_reg,
	output logic [CW-1:0] o_rename_set_copy,

	dispatch_if.src dsp
);

	typedef logic [CW-1:0] copy_t;

	logic free_found;
	copy_t free_copy;

	// Lowest copy of rd that is not busy
	always_comb begin
		free_found = 1'b0;
		free_copy = '0;
		for (int c = RP - 1; c >= 0; c--) begin
			if (!i_rn_busy[i_instr_rd][c]) begin
				free_found = 1'b1;
				free_copy = copy_t'(c);
			end
		end
	end

	assign o_instr_ready = free_found & ~dsp.iq_full & ~dsp.rob_full;
	assign dsp.push = i_instr_valid & o_instr_ready;

	assign dsp.op = i_instr_op;
	assign dsp.imm = i_instr_imm;
	assign dsp.rd = i_instr_rd;
	assign dsp.rd_copy = free_copy;

	// Sources see the copy active before this rename
	assign dsp.rs1 = i_instr_rs1;
	assign dsp.rs1_copy = i_rn_act[i_instr_rs1];
	assign dsp.rs2 = i_instr_rs2;
	assign dsp.rs2_copy = i_rn_act[i_instr_rs2];

	assign o_rename_set_valid = dsp.push;
	assign o_rename_set_reg = i_instr_rd;
	assign o_rename_set_copy = free_copy;

endmodule

`default_nettype wire

// ==== verilog/phy_register.sv ====
/* Physical register block: register file copies with rename-active,
   busy, writeback-done and architectural state per register */
`timescale 1ns/100ps
`default_nettype none

module phy_register import backend_pkg::*; #(
	parameter int RP = RP_DEFAULT,
	localparam int CW = copy_width(RP)
) (
	input logic CLK,
	input logic i_rst,

	writeback_if.sink wb,

	input logic i_rename_set_valid,
	input areg_t i_rename_set_reg,
	input logic [CW-1:0] i_rename_set_copy,

	input logic i_commit_set_valid,
	input areg_t i_commit_set_reg,
	input logic [CW-1:0] i_commit_set_copy,

	output logic [AREG_NUM-1:0][CW-1:0] o_rn_act,
	output logic [AREG_NUM-1:0][RP-1:0] o_rn_busy,
	output logic [AREG_NUM-1:0][RP-1:0] o_wb_done,
	output logic [AREG_NUM-1:0][RP-1:0][XLEN-1:0] o_regfile
);

	typedef logic [CW-1:0] copy_t;

	// Copy that holds the committed value of each register
	copy_t archi [AREG_NUM];

	always_ff @(posedge CLK) begin
		if (i_rst) begin
			for (int r = 0; r < AREG_NUM; r++) begin
				o_rn_act[r] <= '0;
				o_rn_busy[r] <= RP'(1);
				o_wb_done[r] <= RP'(1);
				archi[r] <= '0;
			end
		end else begin
			// New copy becomes the rename target and waits for its result
			if (i_rename_set_valid) begin
				o_rn_act[i_rename_set_reg] <= i_rename_set_copy;
				o_rn_busy[i_rename_set_reg][i_rename_set_copy] <= 1'b1;
				o_wb_done[i_rename_set_reg][i_rename_set_copy] <= 1'b0;
			end

			if (wb.valid) begin
				o_wb_done[wb.rd][wb.copy] <= 1'b1;
			end

			// Retire: previous architectural copy is free again
			if (i_commit_set_valid) begin
				archi[i_commit_set_reg] <= i_commit_set_copy;
				o_rn_busy[i_commit_set_reg][archi[i_commit_set_reg]] <= 1'b0;
			end
		end
	end

	// All registers read zero after reset
	always_ff @(posedge CLK) begin
		if (i_rst) begin
			o_regfile <= '0;
		end else if (wb.valid) begin
			o_regfile[wb.rd][wb.copy] <= wb.data;
		end
	end

endmodule

`default_nettype wire
